//--- logic/alu.sv
// 32-bit ALU, compares return 0 or 1, shift amount from srcB[4:0]
`default_nettype none

module alu import rvPkg::*; (
  input  word_t  srcA,
  input  word_t  srcB,
  input  aluOp_t aluOp,
  output word_t  result,
  output logic   zero
);

  logic [4:0] shamt;
  logic       lessSigned;
  logic       lessUnsigned;

  assign shamt        = srcB[4:0];
  assign lessSigned   = $signed(srcA) < $signed(srcB);
  assign lessUnsigned = srcA < srcB;

  always_comb begin
    case (aluOp)
      Add:     result = srcA + srcB;
      Sub:     result = srcA - srcB;
      And:     result = srcA & srcB;
      Or:      result = srcA | srcB;
      Xor:     result = srcA ^ srcB;
      Sll:     result = srcA << shamt;
      Srl:     result = srcA >> shamt;
      Sra:     result = word_t'($signed(srcA) >>> shamt);
      Slt:     result = {31'b0, lessSigned};
      Sltu:    result = {31'b0, lessUnsigned};
      Sge:     result = {31'b0, ~lessSigned};
      Sgeu:    result = {31'b0, ~lessUnsigned};
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- logic/aluDecoder.sv
// picks the ALU operation from the control state and instruction fields
`default_nettype none

module aluDecoder import rvPkg::*; (
  input  ctrlState_t state,
  input  logic [2:0] funct3,
  input  logic       funct7b5,
  input  opcode_t    opcode,
  output aluOp_t     aluOp
);

  always_comb begin
    aluOp = Add;  // address, link and pc arithmetic
    case (state)
      ExecuteR, ExecuteI: begin
        case (funct3)
          3'b000:  aluOp = (opcode == RType && funct7b5) ? Sub : Add;  // no subi
          3'b001:  aluOp = Sll;
          3'b010:  aluOp = Slt;
          3'b011:  aluOp = Sltu;
          3'b100:  aluOp = Xor;
          3'b101:  aluOp = funct7b5 ? Sra : Srl;
          3'b110:  aluOp = Or;
          default: aluOp = And;
        endcase
      end
      BranchEq: aluOp = Sub;  // zero flag does the compare
      BranchComp: begin
        case (funct3)
          3'b100:  aluOp = Slt;
          3'b101:  aluOp = Sge;
          3'b110:  aluOp = Sltu;
          default: aluOp = Sgeu;
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/controlFsm.sv
// Moore control FSM, one instruction at a time, fixed one-cycle memory
// an unsupported opcode parks the machine in Decode with halted high
`default_nettype none

module controlFsm import rvPkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  opcode_t    opcode,
  input  logic [2:0] funct3,
  input  logic       zeroFlag,
  input  word_t      aluResult,
  input  byteEn_t    storeLanes,
  output ctrlState_t state,
  output aluSrcA_t   aluSrcA,
  output aluSrcB_t   aluSrcB,
  output resultSrc_t resultSrc,
  output adrSrc_t    adrSrc,
  output pcSrc_t     pcSrc,
  output logic       irWrite,
  output logic       regWrite,
  output logic       pcUpdate,
  output byteEn_t    memByteEnable,
  output logic       halted
);

  ctrlState_t nextState;

  always_ff @(posedge clk) begin
    if (reset) state <= Fetch;
    else       state <= nextState;
  end

  always_comb begin
    nextState = Fetch;
    case (state)
      Fetch:     nextState = FetchWait;
      FetchWait: nextState = Decode;
      Decode: begin
        case (opcode)
          RType:      nextState = ExecuteR;
          ITypeLogic: nextState = ExecuteI;
          ITypeLoad:  nextState = MemAdr;
          SType:      nextState = MemAdr;
          BType:      nextState = (funct3[2:1] == 2'b00) ? BranchEq : BranchComp;
          JType:      nextState = UncondJump;
          ITypeJalr:  nextState = JalrCalc;
          UTypeLui:   nextState = Lui;
          UTypeAuipc: nextState = Auipc;
          Fence:      nextState = Fetch;     // no-op
          default:    nextState = Decode;    // unknown opcode, stay here
        endcase
      end
      ExecuteR, ExecuteI, Lui, Auipc, UncondJump: nextState = AluWb;
      JalrCalc:  nextState = JalrLink;
      JalrLink:  nextState = AluWb;
      MemAdr:    nextState = (opcode == SType) ? MemWrite : MemRead;
      MemRead:   nextState = MemWb;
      default:   nextState = Fetch;  // writeback, store and branch states
    endcase
  end

  always_comb begin
    aluSrcA       = OldPc;
    aluSrcB       = ImmExt;
    resultSrc     = AluOut;
    adrSrc        = Pc;
    pcSrc         = Increment;
    irWrite       = 1'b0;
    regWrite      = 1'b0;
    pcUpdate      = 1'b0;
    memByteEnable = '0;
    halted        = 1'b0;

    case (state)
      FetchWait: begin
        irWrite  = 1'b1;
        pcUpdate = 1'b1;  // pc + 4
      end
      Decode: halted = (nextState == Decode);  // ALU forms oldPc + imm meanwhile
      ExecuteR: begin
        aluSrcA = Rd1;
        aluSrcB = Rd2;
      end
      ExecuteI, JalrCalc: aluSrcA = Rd1;
      Lui: aluSrcA = Zero;
      UncondJump: begin
        aluSrcB  = Four;    // link value
        pcSrc    = Jump;    // target latched during Decode
        pcUpdate = 1'b1;
      end
      JalrLink: begin
        aluSrcB  = Four;
        pcSrc    = AluOutAligned;
        pcUpdate = 1'b1;
      end
      MemAdr: begin
        aluSrcA   = Rd1;
        adrSrc    = Result;
        resultSrc = AluResult;  // address goes out straight from the ALU
      end
      MemRead: begin
        aluSrcA = Rd1;  // keeps the address in aluOut for MemWb
        adrSrc  = Result;
      end
      MemWb: begin
        resultSrc = MemData;
        regWrite  = 1'b1;
      end
      MemWrite: begin
        adrSrc        = Result;
        memByteEnable = storeLanes;
      end
      AluWb: regWrite = 1'b1;
      BranchEq: begin
        aluSrcA = Rd1;
        aluSrcB = Rd2;
        if (zeroFlag ^ funct3[0]) begin  // bne inverts the sense
          pcSrc    = Jump;
          pcUpdate = 1'b1;
        end
      end
      BranchComp: begin
        aluSrcA = Rd1;
        aluSrcB = Rd2;
        if (aluResult == 32'd1) begin
          pcSrc    = Jump;
          pcUpdate = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/immExtend.sv
// immediate generator, format chosen by opcode, unknown opcodes give zero
`default_nettype none

module immExtend import rvPkg::*; (
  input  word_t instr,
  output word_t imm
);

  opcode_t opcode;

  assign opcode = instr[6:0];

  always_comb begin
    case (opcode)
      ITypeLogic, ITypeLoad, ITypeJalr:
        imm = {{20{instr[31]}}, instr[31:20]};
      SType:
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      BType:
        imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      UTypeLui, UTypeAuipc:
        imm = {instr[31:12], 12'b0};
      JType:
        imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:
        imm = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/registerFile.sv
// 32 x 32 register file, asynchronous reads, x0 always reads zero
`default_nettype none

module registerFile import rvPkg::*; (
  input  wire      clk,
  input  regAddr_t addrA,
  input  regAddr_t addrB,
  input  regAddr_t addrW,
  input  logic     writeEn,
  input  word_t    writeData,
  output word_t    readA,
  output word_t    readB
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (writeEn && addrW != '0) regs[addrW] <= writeData;
  end

  // x0 is never written, so force the read value
  assign readA = (addrA == '0) ? '0 : regs[addrA];
  assign readB = (addrB == '0) ? '0 : regs[addrB];

endmodule

`default_nettype wire

//--- logic/rvMulticycleCore.sv
// multicycle RV32I core; memory must return read data exactly one cycle later
// accesses are assumed aligned, lh/lhu and traps are not supported
`default_nettype none

module rvMulticycleCore import rvPkg::*; (
  input  wire     clk,
  input  wire     reset,
  output word_t   memAddr,
  output word_t   memWriteData,
  output byteEn_t memByteEnable,
  input  word_t   memReadData,
  output logic    halted
);

  word_t pc, oldPc, instr, rd1Reg, rd2Reg, aluOut;
  word_t rd1, rd2, immExt, srcA, srcB, aluResult, result, loadData, pcNext;
  logic [7:0] loadByte;
  logic [2:0] funct3;
  opcode_t    opcode;
  byteEn_t    storeLanes;
  logic       zeroFlag, irWrite, regWrite, pcUpdate;
  ctrlState_t state;
  aluSrcA_t   aluSrcA;
  aluSrcB_t   aluSrcB;
  resultSrc_t resultSrc;
  adrSrc_t    adrSrc;
  pcSrc_t     pcSrc;
  aluOp_t     aluOp;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  controlFsm fsm (.clk, .reset, .opcode, .funct3, .zeroFlag, .aluResult, .storeLanes,
    .state, .aluSrcA, .aluSrcB, .resultSrc, .adrSrc, .pcSrc, .irWrite, .regWrite,
    .pcUpdate, .memByteEnable, .halted);
  aluDecoder aluDec (.state, .funct3, .funct7b5(instr[30]), .opcode, .aluOp);
  alu aluUnit (.srcA, .srcB, .aluOp, .result(aluResult), .zero(zeroFlag));
  registerFile regFile (.clk, .addrA(instr[19:15]), .addrB(instr[24:20]),
    .addrW(instr[11:7]), .writeEn(regWrite), .writeData(result), .readA(rd1), .readB(rd2));
  immExtend immGen (.instr, .imm(immExt));

  always_ff @(posedge clk) begin
    if (reset) pc <= '0;
    else if (pcUpdate) pc <= pcNext;
  end

  always_ff @(posedge clk) begin
    if (irWrite) begin
      instr <= memReadData;
      oldPc <= pc;  // pc of the instruction now in instr
    end
    rd1Reg <= rd1;
    rd2Reg <= rd2;
    aluOut <= aluResult;
  end

  always_comb begin
    case (aluSrcA)
      Rd1:     srcA = rd1Reg;
      Zero:    srcA = '0;
      default: srcA = oldPc;
    endcase
    case (aluSrcB)
      Rd2:     srcB = rd2Reg;
      Four:    srcB = 32'd4;
      default: srcB = immExt;
    endcase
    case (resultSrc)
      AluResult: result = aluResult;
      MemData:   result = loadData;
      default:   result = aluOut;
    endcase
    case (pcSrc)
      Jump:          pcNext = aluOut;
      AluOutAligned: pcNext = {aluOut[31:1], 1'b0};  // jalr clears bit 0
      default:       pcNext = pc + 32'd4;
    endcase
  end

  assign memAddr = (adrSrc == Result) ? result : pc;

  // store lanes and replicated data, address low bits held in aluOut
  always_comb begin
    case (funct3)
      3'b000: begin
        storeLanes   = byteEn_t'(4'b0001 << aluOut[1:0]);
        memWriteData = {4{rd2Reg[7:0]}};
      end
      3'b001: begin
        storeLanes   = aluOut[1] ? 4'b1100 : 4'b0011;
        memWriteData = {2{rd2Reg[15:0]}};
      end
      default: begin
        storeLanes   = 4'b1111;
        memWriteData = rd2Reg;
      end
    endcase
  end

  // load formatting, lb sign extends and lbu zero extends
  assign loadByte = memReadData[8*aluOut[1:0] +: 8];

  always_comb begin
    case (funct3)
      3'b000:  loadData = {{24{loadByte[7]}}, loadByte};
      3'b100:  loadData = {24'b0, loadByte};
      default: loadData = memReadData;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/rvPkg.sv
// shared types and constants for the RV32I multicycle core
// datapath is fixed at 32 bits, opcodes cover only the supported subset
`default_nettype none

package rvPkg;

  typedef logic [31:0] word_t;    // data or byte address
  typedef logic [4:0]  regAddr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [3:0]  byteEn_t;  // one bit per byte lane

  // major opcode classes
  localparam opcode_t RType      = 7'b0110011;
  localparam opcode_t ITypeLogic = 7'b0010011;
  localparam opcode_t ITypeLoad  = 7'b0000011;
  localparam opcode_t ITypeJalr  = 7'b1100111;
  localparam opcode_t SType      = 7'b0100011;
  localparam opcode_t BType      = 7'b1100011;
  localparam opcode_t JType      = 7'b1101111;
  localparam opcode_t UTypeLui   = 7'b0110111;
  localparam opcode_t UTypeAuipc = 7'b0010111;
  localparam opcode_t Fence      = 7'b0001111;

  typedef enum logic [4:0] {
    Fetch,
    FetchWait,   // instruction word arrives from memory
    Decode,
    ExecuteR,
    ExecuteI,
    Lui,
    Auipc,
    UncondJump,
    JalrCalc,
    JalrLink,
    MemAdr,
    MemRead,
    MemWb,
    MemWrite,
    AluWb,
    BranchEq,    // beq and bne
    BranchComp   // signed and unsigned compares
  } ctrlState_t;

  typedef enum logic [1:0] {OldPc, Rd1, Zero} aluSrcA_t;
  typedef enum logic [1:0] {Rd2, ImmExt, Four} aluSrcB_t;
  typedef enum logic [1:0] {AluOut, AluResult, MemData} resultSrc_t;
  typedef enum logic {Pc, Result} adrSrc_t;
  typedef enum logic [1:0] {Increment, Jump, AluOutAligned} pcSrc_t;

  typedef enum logic [3:0] {
    Add, Sub, And, Or, Xor,
    Sll, Srl, Sra,
    Slt, Sltu, Sge, Sgeu
  } aluOp_t;

endpackage

`default_nettype wire

//--- rvMulticycleCore.f
logic/rvPkg.sv
logic/alu.sv
logic/aluDecoder.sv
logic/controlFsm.sv
logic/immExtend.sv
logic/registerFile.sv
logic/rvMulticycleCore.sv
verif/rvCore_checker.sv
verif/rvCoreTb.sv

//--- verif/rvCoreTb.sv
// runs a table of short programs on the core and checks every store it makes
// 1K-word memory with one-cycle read latency, every program ends in an illegal opcode
`default_nettype none

module rvCoreTb import rvPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    NumRows   = 36;
  localparam int    MaxWords  = 16;
  localparam int    MaxStores = 4;
  localparam int    Timeout   = 400;
  localparam word_t Illegal   = 32'h0000_007F;  // opcode 1111111 is not RV32I
  localparam word_t DataBase  = 32'h0000_0200;

  logic    clk;
  logic    reset;
  word_t   memAddr;
  word_t   memWriteData;
  word_t   memReadData;
  byteEn_t memByteEnable;
  logic    halted;

  word_t   mem [1024];
  word_t   prog [NumRows][MaxWords];
  int      progLen [NumRows];
  word_t   expAddr [NumRows][MaxStores];
  word_t   expData [NumRows][MaxStores];
  byteEn_t expLanes [NumRows][MaxStores];
  int      expCount [NumRows];
  bit      aluRow [NumRows];
  int      nRows;
  int      curRow;
  int      storeIdx;
  int      errors;

  rvMulticycleCore DUT (.clk, .reset, .memAddr, .memWriteData, .memByteEnable,
    .memReadData, .halted);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // read data shows up one cycle after the address, stores land at the edge
  always @(posedge clk) begin
    memReadData <= mem[memAddr[11:2]];
    for (int i = 0; i < 4; i++) begin
      if (memByteEnable[i]) mem[memAddr[11:2]][8*i +: 8] <= memWriteData[8*i +: 8];
    end
  end

  function automatic word_t encR(logic [2:0] f3, logic alt, logic [4:0] rd, rs1, rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, RType};
  endfunction

  function automatic word_t encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                 logic [4:0] rd, opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t encS(logic [11:0] imm, logic [4:0] rs2, rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], SType};
  endfunction

  function automatic word_t encB(logic [12:0] imm, logic [4:0] rs1, rs2, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BType};
  endfunction

  function automatic word_t encU(logic [19:0] imm, logic [4:0] rd, opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic word_t encJ(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JType};
  endfunction

  // OP and OP-IMM results per the ISA, alt marks sub and sra
  function automatic word_t aluRule(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branchRule(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic word_t fillWord(logic [9:0] idx);
    return {~idx, 6'h2A, idx, 6'h15};
  endfunction

  task automatic startRow(bit isAlu);
    progLen[nRows]  = 0;
    expCount[nRows] = 0;
    aluRow[nRows]   = isAlu;
    nRows++;
  endtask

  task automatic emit(word_t w);
    prog[nRows-1][progLen[nRows-1]] = w;
    progLen[nRows-1]++;
  endtask

  task automatic expectStore(word_t addr, word_t data, byteEn_t lanes);
    int r;
    r = nRows - 1;
    expAddr[r][expCount[r]]  = addr;
    expData[r][expCount[r]]  = data;
    expLanes[r][expCount[r]] = lanes;
    expCount[r]++;
  endtask

  task automatic loadReg(logic [4:0] rd, word_t v);
    word_t upper;
    upper = v + 32'h800;  // addi sign extends the low 12 bits
    emit(encU(upper[31:12], rd, UTypeLui));
    emit(encI(v[11:0], rd, 3'b000, rd, ITypeLogic));
  endtask

  task automatic buildAluRows();
    word_t       a;
    word_t       b;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic        alt;
    for (int k = 0; k < 10; k++) begin  // eight funct3 codes, then sub and sra
      f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
      alt = (k >= 8);
      a   = $urandom;
      b   = $urandom;
      startRow(1'b1);
      loadReg(1, a);
      loadReg(2, b);
      emit(encR(f3, alt, 3, 1, 2));
      emit(encS(DataBase[11:0], 3, 0, 3'b010));
      emit(Illegal);
      expectStore(DataBase, aluRule(f3, alt, a, b), 4'hF);
    end
    for (int k = 0; k < 9; k++) begin  // immediate forms, srai last
      f3  = (k < 8) ? 3'(k) : 3'd5;
      alt = (k == 8);
      a   = $urandom;
      imm = 12'($urandom);
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm = {1'b0, alt, 5'b0, imm[4:0]};
        b   = {27'b0, imm[4:0]};
      end else begin
        b = {{20{imm[11]}}, imm};
      end
      startRow(1'b1);
      loadReg(1, a);
      emit(encI(imm, 1, f3, 3, ITypeLogic));
      emit(encS(DataBase[11:0], 3, 0, 3'b010));
      emit(Illegal);
      expectStore(DataBase, aluRule(f3, alt, a, b), 4'hF);
    end
  endtask

  task automatic buildJumpRow();
    logic [19:0] u1;
    logic [19:0] u2;
    u1 = 20'($urandom);
    u2 = 20'($urandom);
    startRow(1'b0);
    emit(encU(u1, 3, UTypeLui));
    emit(encS(12'h200, 3, 0, 3'b010));
    emit(encU(u2, 4, UTypeAuipc));                 // pc 8
    emit(encS(12'h204, 4, 0, 3'b010));
    emit(encJ(21'd8, 5));                          // pc 16, links 20
    emit(encS(12'h20C, 5, 0, 3'b010));             // skipped
    emit(encS(12'h208, 5, 0, 3'b010));
    emit(encI(12'd45, 0, 3'b000, 6, ITypeLogic));  // odd target for jalr
    emit(encI(12'd0, 6, 3'b000, 7, ITypeJalr));    // pc 32, links 36, lands on 44
    emit(encS(12'h20C, 7, 0, 3'b010));             // skipped
    emit(encS(12'h20C, 6, 0, 3'b010));             // skipped
    emit(encU(20'd0, 8, UTypeAuipc));              // pc 44, the landing pc
    emit(encR(3'b000, 1'b0, 7, 7, 8));             // link plus landing pc
    emit(encS(12'h20C, 7, 0, 3'b010));
    emit(32'h0000_000F);                           // fence
    emit(Illegal);
    expectStore(32'h200, {u1, 12'b0}, 4'hF);
    expectStore(32'h204, 32'd8 + {u2, 12'b0}, 4'hF);
    expectStore(32'h208, 32'd20, 4'hF);
    expectStore(32'h20C, 32'd36 + 32'd44, 4'hF);
  endtask

  task automatic buildBranchRows();
    word_t      a;
    word_t      b;
    word_t      x;
    word_t      y;
    logic [2:0] f3;
    for (int j = 0; j < 6; j++) begin
      f3 = (j < 2) ? 3'(j) : 3'(j + 2);
      a  = $urandom;
      b  = a ^ ($urandom | 32'h1);  // never equal to a
      for (int t = 0; t < 2; t++) begin
        if (!f3[2]) begin  // equal pair, then unequal pair
          x = a;
          y = (t == 0) ? a : b;
        end else begin     // same pair swapped
          x = (t == 0) ? a : b;
          y = (t == 0) ? b : a;
        end
        startRow(1'b0);
        loadReg(1, x);
        loadReg(2, y);
        emit(encB(13'd12, 1, 2, f3));
        emit(encI(12'd1, 0, 3'b000, 3, ITypeLogic));  // fall-through marker
        emit(encJ(21'd8, 0));
        emit(encI(12'd2, 0, 3'b000, 3, ITypeLogic));  // taken marker
        emit(encS(DataBase[11:0], 3, 0, 3'b010));
        emit(Illegal);
        expectStore(DataBase, branchRule(f3, x, y) ? 32'd2 : 32'd1, 4'hF);
      end
    end
  endtask

  task automatic buildMemRows();
    word_t v;
    word_t sbAddr;
    word_t shAddr;
    for (int lane = 0; lane < 4; lane++) begin
      v      = $urandom;
      v[7]   = lane % 2;  // both signs of the loaded byte
      sbAddr = 32'h300 + lane;
      shAddr = 32'h304 + (lane & 2);
      startRow(1'b0);
      loadReg(1, v);
      emit(encS(sbAddr[11:0], 1, 0, 3'b000));
      emit(encS(shAddr[11:0], 1, 0, 3'b001));
      emit(encI(sbAddr[11:0], 0, 3'b000, 2, ITypeLoad));  // lb
      emit(encI(sbAddr[11:0], 0, 3'b100, 3, ITypeLoad));  // lbu
      emit(encS(12'h308, 2, 0, 3'b010));
      emit(encS(12'h30C, 3, 0, 3'b010));
      emit(Illegal);
      expectStore(sbAddr, {4{v[7:0]}}, byteEn_t'(4'b0001 << lane));
      expectStore(shAddr, {2{v[15:0]}}, (lane >= 2) ? 4'b1100 : 4'b0011);
      expectStore(32'h308, {{24{v[7]}}, v[7:0]}, 4'hF);
      expectStore(32'h30C, {24'b0, v[7:0]}, 4'hF);
    end
  endtask

  task automatic compareWord(string name, word_t got, word_t exp);
    assert (got === exp) else begin
      errors++;
      $display("Error %0t ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  always @(negedge clk) begin
    if (!reset && memByteEnable != '0) begin
      if (storeIdx >= expCount[curRow]) begin
        errors++;
        $display("Row %0d: unexpected extra store to address %h", curRow, memAddr);
      end else begin
        compareWord("memAddr", memAddr, expAddr[curRow][storeIdx]);
        compareWord("memWriteData", memWriteData, expData[curRow][storeIdx]);
        compareWord("memByteEnable", word_t'(memByteEnable),
          word_t'(expLanes[curRow][storeIdx]));
      end
      storeIdx++;
    end
  end

  task automatic runRow(int r);
    int cycles;
    @(posedge clk);
    reset <= 1'b1;
    @(negedge clk);
    for (int i = 0; i < 1024; i++) mem[i] = fillWord(10'(i));
    for (int i = 0; i < progLen[r]; i++) mem[i] = prog[r][i];
    curRow   = r;
    storeIdx = 0;
    @(posedge clk);
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);  // first cycle out of reset, core in Fetch
    cycles = 1;
    compareWord("memAddr", memAddr, 32'h0);
    compareWord("halted", word_t'(halted), 32'h0);
    compareWord("memByteEnable", word_t'(memByteEnable), 32'h0);
    while (!halted && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("Row %0d: timed out after %0d cycles waiting for halted", r, Timeout);
    end else if (aluRow[r] && cycles > 5 * (progLen[r] - 1) + 3) begin
      errors++;
      $display("Row %0d: halted after %0d cycles, limit is %0d", r, cycles,
        5 * (progLen[r] - 1) + 3);
    end
    repeat (4) @(negedge clk);  // a halted core must stay quiet
    if (storeIdx < expCount[r]) begin
      errors++;
      $display("Row %0d: missing stores, saw %0d of %0d", r, storeIdx, expCount[r]);
    end
  endtask

  initial begin
    reset       = 1'b1;
    memReadData = '0;
    errors      = 0;
    nRows       = 0;
    curRow      = 0;
    storeIdx    = 0;
    void'($urandom(32'ha0b4));
    buildAluRows();
    buildJumpRow();
    buildBranchRows();
    buildMemRows();
    for (int r = 0; r < nRows; r++) runRow(r);
    $display("Run complete: %0d rows, %0d errors, %0d assertion failures", nRows, errors,
      DUT.coreChecks.failures);
    if (errors == 0 && DUT.coreChecks.failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/rvCore_checker.sv
// concurrent checks on the core's memory bus and halt flag
// relies on the synchronous reset putting the FSM in Fetch at the reset edge
`default_nettype none

module rvCoreChecker import rvPkg::*; (
  input wire     clk,
  input wire     reset,
  input byteEn_t memByteEnable,
  input logic    halted
);

  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;  // assertion failures so far

  // no store while in reset or in the Fetch cycle right after it
  noStoreAroundReset: assert property (@(posedge clk)
    ($past(reset) || $past(reset, 2)) |-> memByteEnable == '0)
    else begin
      $error("store enable active around reset");
      failures++;
    end

  // once halted, only reset releases the core
  haltSticky: assert property (@(posedge clk) $fell(halted) |-> $past(reset))
    else begin
      $error("halted dropped without reset");
      failures++;
    end

  legalLanes: assert property (@(posedge clk) memByteEnable inside
    {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111})
    else begin
      $error("illegal byte lane pattern on memByteEnable");
      failures++;
    end

endmodule

bind rvMulticycleCore rvCoreChecker coreChecks (.clk, .reset, .memByteEnable, .halted);

`default_nettype wire
